//--- common/demod_pkg.sv
//**************************************************************************
// Demodulator core shared definitions
//**************************************************************************

package demod_pkg;

  //************************************************************************
  // Widths
  //************************************************************************
  localparam int ADC_W      = 14;
  localparam int SAMPLE_W   = 18;
  localparam int DAC_W      = 14;
  localparam int SAMPLE_PAD = 4;   // Zero bits below the ADC word
  localparam int BUS_W      = 16;
  localparam int REG_W      = 32;
  localparam int ADDR_W     = 12;  // Bit 0 always zero

  //************************************************************************
  // Address map
  //************************************************************************
  localparam logic [ADDR_W-1:0] MISC_BASE = 12'hFE0;
  localparam int MISC_DEC_LSB = 4;  // Space decoded on bits 11:4
  localparam int MISC_REG_LSB = 2;  // Register offset on bits 3:2

  // Firmware version, upper half of the version register
  localparam logic [BUS_W-1:0] VER_NUMBER = 16'h006d;

  // Core reset lasts RESET_STRETCH+1 cycles
  localparam int RESET_STRETCH = 5;
  localparam int RST_CNT_W = $clog2(RESET_STRETCH + 1);
  localparam logic [RST_CNT_W-1:0] RST_CNT_LOAD = RST_CNT_W'(RESET_STRETCH);

  // Offset binary zero
  localparam logic [DAC_W-1:0] DAC_MIDSCALE = 14'h2000;

  //************************************************************************
  // Types
  //************************************************************************
  typedef enum logic {
    SPACE_NONE = 1'b0,
    SPACE_MISC = 1'b1
  } host_space_e;

  // Offsets within the misc space, in 32-bit registers
  typedef enum logic [1:0] {
    MISC_RESET   = 2'd0,
    MISC_VERSION = 2'd1,
    MISC_CLOCK   = 2'd2
  } misc_reg_e;

  typedef logic signed [SAMPLE_W-1:0] sample_t;
  typedef logic [DAC_W-1:0] dac_word_t;

  // Decoded processor bus request
  typedef struct packed {
    host_space_e space;     // Selected space, chip select included
    misc_reg_e   reg_sel;
    logic        hi_half;   // Upper 16 bits of the register
    logic        rd;        // Read level
    logic        wr_stb;    // Write strobe, one cycle
    logic        sel_rise;  // Start of a misc access, one cycle
  } host_req_t;

endpackage

//--- logic/host_decode.sv
//**************************************************************************
// Processor bus decode
//**************************************************************************

`timescale 1ns/1ps

module host_decode (
  input  logic                              ck933,
  input  logic                              clockCounterEn,
  input  logic                              cs_n_i,
  input  logic                              rd_n_i,
  input  logic                              we_n_i,
  input  logic [demod_pkg::ADDR_W-1:1]      addr_i,
  output demod_pkg::host_req_t              req_o
);

  logic                         cs_n_q;
  logic                         rd_n_q;
  logic                         we_n_q;
  logic                         we_n_qq;   // Previous we_n_q for edge detect
  logic [demod_pkg::ADDR_W-1:1] addr_q;
  logic                         misc_hit;
  logic                         misc_sel;
  logic                         misc_sel_q;

  // Bus pins registered once, strobes idle high
  always_ff @(posedge ck933 or posedge clockCounterEn) begin
    if (clockCounterEn) begin
      cs_n_q     <= 1'b1;
      rd_n_q     <= 1'b1;
      we_n_q     <= 1'b1;
      we_n_qq    <= 1'b1;
      misc_sel_q <= 1'b0;
    end else begin
      cs_n_q     <= cs_n_i;
      rd_n_q     <= rd_n_i;
      we_n_q     <= we_n_i;
      we_n_qq    <= we_n_q;
      misc_sel_q <= misc_sel;
    end
  end

  always_ff @(posedge ck933) begin
    addr_q <= addr_i;
  end

  assign misc_hit = (addr_q[demod_pkg::ADDR_W-1:demod_pkg::MISC_DEC_LSB] ==
                     demod_pkg::MISC_BASE[demod_pkg::ADDR_W-1:demod_pkg::MISC_DEC_LSB]);
  assign misc_sel = ~cs_n_q & misc_hit;

  always_comb begin
    req_o.space    = misc_sel ? demod_pkg::SPACE_MISC : demod_pkg::SPACE_NONE;
    req_o.reg_sel  = demod_pkg::misc_reg_e'(addr_q[demod_pkg::MISC_REG_LSB +: 2]);
    req_o.hi_half  = addr_q[1];
    req_o.rd       = misc_sel & ~rd_n_q;
    req_o.wr_stb   = we_n_q & ~we_n_qq & ~cs_n_q;  // Rising edge of we_n
    req_o.sel_rise = misc_sel & ~misc_sel_q;
  end

endmodule

//--- misc/misc_regs.sv
//**************************************************************************
// Misc register space
//**************************************************************************

`timescale 1ns/1ps

module misc_regs (
  input  logic                          ck933,
  input  logic                          clockCounterEn,
  input  demod_pkg::host_req_t          req_i,
  output logic [demod_pkg::BUS_W-1:0]   rd_data_o,
  output logic                          rst_req_o
);

  logic [demod_pkg::REG_W-1:0] clock_count;
  logic [demod_pkg::REG_W-1:0] clock_hold;
  logic [demod_pkg::REG_W-1:0] reg_value;
  logic                        misc_acc;
  logic                        clock_clr;
  logic                        rd_q;

  assign misc_acc = (req_i.space == demod_pkg::SPACE_MISC);

  // Host write to the clock register restarts the count
  assign clock_clr = req_i.wr_stb & misc_acc &
                     (req_i.reg_sel == demod_pkg::MISC_CLOCK);

  //************************************************************************
  // Clock cycle counter
  //************************************************************************

  always_ff @(posedge ck933 or posedge clockCounterEn) begin
    if (clockCounterEn) begin
      clock_count <= '0;
      clock_hold  <= '0;
    end else begin
      if (clock_clr) begin
        clock_count <= '0;
      end else begin
        clock_count <= clock_count + 1'b1;  // Free running, wraps
      end
      // Snapshot taken as a misc access begins
      if (req_i.sel_rise) begin
        clock_hold <= clock_count;
      end
    end
  end

  //************************************************************************
  // Soft reset request
  //************************************************************************

  always_ff @(posedge ck933 or posedge clockCounterEn) begin
    if (clockCounterEn) begin
      rd_q <= 1'b0;
    end else begin
      rd_q <= req_i.rd;
    end
  end

  // One pulse per new read of the reset register
  assign rst_req_o = req_i.rd & ~rd_q &
                     (req_i.reg_sel == demod_pkg::MISC_RESET);

  //************************************************************************
  // Read data
  //************************************************************************

  always_comb begin
    reg_value = '0;
    if (misc_acc) begin
      case (req_i.reg_sel)
        demod_pkg::MISC_VERSION: begin
          reg_value = {demod_pkg::VER_NUMBER, {demod_pkg::BUS_W{1'b0}}};
        end
        demod_pkg::MISC_CLOCK: begin
          reg_value = clock_hold;
        end
        default: begin
          reg_value = '0;                 // Reset reg and unused offset
        end
      endcase
    end
  end

  // Half select by address bit 1
  assign rd_data_o = req_i.hi_half ? reg_value[demod_pkg::REG_W-1:demod_pkg::BUS_W]
                                   : reg_value[demod_pkg::BUS_W-1:0];

endmodule

//--- misc/soft_reset.sv
//**************************************************************************
// Core reset stretcher
//**************************************************************************

`timescale 1ns/1ps

module soft_reset (
  input  logic ck933,
  input  logic clockCounterEn,
  input  logic rst_req_i,
  output logic core_rst_o
);

  logic                            req_s0;
  logic                            req_s1;
  logic [demod_pkg::RST_CNT_W-1:0] stretch_cnt;

  // Request chain then down-counter
  always_ff @(posedge ck933 or posedge clockCounterEn) begin
    if (clockCounterEn) begin
      req_s0      <= 1'b0;
      req_s1      <= 1'b0;
      stretch_cnt <= '0;
    end else begin
      req_s0 <= rst_req_i;
      req_s1 <= req_s0;
      if (req_s1) begin
        stretch_cnt <= demod_pkg::RST_CNT_LOAD;  // Retrigger extends
      end else if (stretch_cnt != '0) begin
        stretch_cnt <= stretch_cnt - 1'b1;
      end
    end
  end

  // High from the second flop until the count empties
  assign core_rst_o = req_s1 | (stretch_cnt != '0);

endmodule

//--- logic/dac_path.sv
//**************************************************************************
// ADC capture and DAC format pipeline
//**************************************************************************

`timescale 1ns/1ps

module dac_path (
  input  logic                         ck933,
  input  logic                         clockCounterEn,
  input  logic                         core_rst_i,
  input  logic [demod_pkg::ADC_W-1:0]  adc_d_i,
  output demod_pkg::dac_word_t         dac_d_o
);

  demod_pkg::sample_t   adc_sample;  // Stage one
  demod_pkg::dac_word_t dac_next;

  //************************************************************************
  // Stage one, ADC reclock
  //************************************************************************

  // Word sits at the top of the sample
  always_ff @(posedge ck933) begin
    adc_sample <= {adc_d_i, {demod_pkg::SAMPLE_PAD{1'b0}}};
  end

  //************************************************************************
  // Stage two, DAC format
  //************************************************************************

  // Upper bits, two's complement to offset binary
  assign dac_next = {~adc_sample[demod_pkg::SAMPLE_W-1],
                     adc_sample[demod_pkg::SAMPLE_W-2 -: demod_pkg::DAC_W-1]};

  always_ff @(posedge ck933 or posedge clockCounterEn) begin
    if (clockCounterEn) begin
      dac_d_o <= demod_pkg::DAC_MIDSCALE;
    end else if (core_rst_i) begin
      dac_d_o <= demod_pkg::DAC_MIDSCALE;   // Quiet output while in reset
    end else begin
      dac_d_o <= dac_next;
    end
  end

endmodule

//--- logic/demod_top.sv
//**************************************************************************
// Demodulator host core and DAC loopback
//**************************************************************************

`timescale 1ns/1ps

module demod_top (
  input  logic                         ck933,
  input  logic                         clockCounterEn,
  input  logic                         cs_n_i,
  input  logic                         rd_n_i,
  input  logic                         we_n_i,
  input  logic [demod_pkg::ADDR_W-1:1] addr_i,
  input  logic [demod_pkg::ADC_W-1:0]  adc_d_i,
  output logic [demod_pkg::BUS_W-1:0]  data_o,
  output logic                         data_oe_o,
  output demod_pkg::dac_word_t         dac_d_o,
  output logic                         dac_rst_o
);

  demod_pkg::host_req_t        host_req;
  logic [demod_pkg::BUS_W-1:0] misc_rd_data;
  logic                        rst_req;
  logic                        core_rst;

  //************************************************************************
  // Host interface
  //************************************************************************

  host_decode u_host_decode (
    .ck933          (ck933),
    .clockCounterEn (clockCounterEn),
    .cs_n_i         (cs_n_i),
    .rd_n_i         (rd_n_i),
    .we_n_i         (we_n_i),
    .addr_i         (addr_i),
    .req_o          (host_req)
  );

  misc_regs u_misc_regs (
    .ck933          (ck933),
    .clockCounterEn (clockCounterEn),
    .req_i          (host_req),
    .rd_data_o      (misc_rd_data),
    .rst_req_o      (rst_req)
  );

  soft_reset u_soft_reset (
    .ck933          (ck933),
    .clockCounterEn (clockCounterEn),
    .rst_req_i      (rst_req),
    .core_rst_o     (core_rst)
  );

  // Bus driven straight from the pins
  assign data_oe_o = ~cs_n_i & ~rd_n_i;
  assign data_o    = (host_req.space == demod_pkg::SPACE_MISC) ? misc_rd_data : '0;

  //************************************************************************
  // Sample loopback
  //************************************************************************

  dac_path u_dac_path (
    .ck933          (ck933),
    .clockCounterEn (clockCounterEn),
    .core_rst_i     (core_rst),
    .adc_d_i        (adc_d_i),
    .dac_d_o        (dac_d_o)
  );

  assign dac_rst_o = core_rst;  // DAC held in reset with the core

endmodule

//--- sim/demod_checker.sv
//**************************************************************************
// Demodulator top level assertions
//**************************************************************************

`timescale 1ns/1ps

module demod_checker (
  input logic                 ck933,
  input logic                 clockCounterEn,
  input demod_pkg::host_req_t req_i,
  input logic                 data_oe_i,
  input demod_pkg::dac_word_t dac_d_i,
  input logic                 dac_rst_i
);

  int unsigned rst_len;   // Cycles of dac reset so far

  always_ff @(posedge ck933 or posedge clockCounterEn) begin
    if (clockCounterEn) begin
      rst_len <= 0;
    end else if (dac_rst_i) begin
      rst_len <= rst_len + 1;
    end else begin
      rst_len <= 0;
    end
  end

  // Registered read level follows the output enable by one cycle
  oe_then_read: assert property (@(posedge ck933) disable iff (clockCounterEn)
    req_i.rd == ($past(data_oe_i) && (req_i.space == demod_pkg::SPACE_MISC)))
    else $error("read request does not follow data_oe_o by one cycle");

  midscale_in_reset: assert property (@(posedge ck933) disable iff (clockCounterEn)
    dac_rst_i |=> (dac_d_i == demod_pkg::DAC_MIDSCALE))
    else $error("dac_d_o is not midscale during the core reset");

  reset_length: assert property (@(posedge ck933) disable iff (clockCounterEn)
    dac_rst_i |-> (rst_len < demod_pkg::RESET_STRETCH + 1))
    else $error("dac_rst_o pulse longer than the stretch");

endmodule

bind demod_top demod_checker u_checker (
  .ck933          (ck933),
  .clockCounterEn (clockCounterEn),
  .req_i          (host_req),
  .data_oe_i      (data_oe_o),
  .dac_d_i        (dac_d_o),
  .dac_rst_i      (dac_rst_o)
);

//--- sim/tb_demod_top.sv
//**************************************************************************
// Demodulator core testbench
//**************************************************************************

`timescale 1ns/1ps

module tb_demod_top;

  localparam int SAMPLE_RUNS   = 300;
  localparam int CLOCK_RUNS    = 4;
  localparam int UNMAPPED_RUNS = 20;
  // Cycle budget per test, upper bounds
  localparam int RESET_CYCLES    = 5;
  localparam int SAMPLE_CYCLES   = SAMPLE_RUNS + 2;
  localparam int VERSION_CYCLES  = 12;
  localparam int CLOCK_CYCLES    = CLOCK_RUNS * (3 + 200 + 7);
  localparam int SOFT_CYCLES     = 13;
  localparam int UNMAPPED_CYCLES = UNMAPPED_RUNS * 3;
  localparam int TIMEOUT_CYCLES  = 2 * (RESET_CYCLES + SAMPLE_CYCLES + VERSION_CYCLES +
                                        CLOCK_CYCLES + SOFT_CYCLES + UNMAPPED_CYCLES);

  logic                         ck933;
  logic                         clockCounterEn;
  logic                         cs_n_i;
  logic                         rd_n_i;
  logic                         we_n_i;
  logic [demod_pkg::ADDR_W-1:1] addr_i;
  logic [demod_pkg::ADC_W-1:0]  adc_d_i;
  logic [demod_pkg::BUS_W-1:0]  data_o;
  logic                         data_oe_o;
  demod_pkg::dac_word_t         dac_d_o;
  logic                         dac_rst_o;

  int unsigned cycle_count = 0;
  int          err_count = 0;
  int          check_total = 0;
  int          tests_run = 0;
  int          test_err_base = 0;
  logic [demod_pkg::ADC_W-1:0] adc_queue[$];   // Samples in flight

  demod_top u_dut (
    .ck933          (ck933),
    .clockCounterEn (clockCounterEn),
    .cs_n_i         (cs_n_i),
    .rd_n_i         (rd_n_i),
    .we_n_i         (we_n_i),
    .addr_i         (addr_i),
    .adc_d_i        (adc_d_i),
    .data_o         (data_o),
    .data_oe_o      (data_oe_o),
    .dac_d_o        (dac_d_o),
    .dac_rst_o      (dac_rst_o)
  );

  always #10 ck933 = ~ck933;

  // Edge counter and run limit
  always @(posedge ck933) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Run stopped: no result after %0d cycles", TIMEOUT_CYCLES);
      $display("Test FAILED");
      $finish;
    end
  end

  //************************************************************************
  // Compare tasks
  //************************************************************************

  task automatic check_dac(input string name, input demod_pkg::dac_word_t exp,
                           input demod_pkg::dac_word_t act);
    check_total++;
    if (act !== exp) begin
      err_count++;
      $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_bus(input string name, input logic [demod_pkg::BUS_W-1:0] exp,
                           input logic [demod_pkg::BUS_W-1:0] act);
    check_total++;
    if (act !== exp) begin
      err_count++;
      $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    check_total++;
    if (act !== exp) begin
      err_count++;
      $display("CHECK FAILED %s: expected %b, actual %b", name, exp, act);
    end
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    $display("%-16s %s, %0d errors", name,
             (err_count == test_err_base) ? "passed" : "failed", err_count - test_err_base);
    test_err_base = err_count;
  endtask

  //************************************************************************
  // Bus helpers and model
  //************************************************************************

  task automatic step_cycle();
    @(posedge ck933);
    #2;
  endtask

  task automatic bus_idle();
    cs_n_i = 1'b1;
    rd_n_i = 1'b1;
    we_n_i = 1'b1;
  endtask

  function automatic logic [demod_pkg::ADDR_W-1:1] misc_addr(input demod_pkg::misc_reg_e sel,
                                                             input logic hi);
    logic [demod_pkg::ADDR_W-1:0] full;
    full = demod_pkg::MISC_BASE;
    full[3:2] = sel;
    full[1] = hi;                           // Register half
    return full[demod_pkg::ADDR_W-1:1];
  endfunction

  // Padded sample, top bits kept, sign flipped to offset binary
  function automatic demod_pkg::dac_word_t expected_dac(input logic [demod_pkg::ADC_W-1:0] adc);
    logic [demod_pkg::SAMPLE_W-1:0] sample;
    demod_pkg::dac_word_t           top;
    sample = {adc, {demod_pkg::SAMPLE_PAD{1'b0}}};
    top = sample[demod_pkg::SAMPLE_W-1 -: demod_pkg::DAC_W];
    top[demod_pkg::DAC_W-1] = ~top[demod_pkg::DAC_W-1];
    return top;
  endfunction

  // Returns the last edge before we_n rises
  task automatic write_reg(input demod_pkg::misc_reg_e sel, output int unsigned rise_edge);
    step_cycle();
    cs_n_i = 1'b0;
    we_n_i = 1'b0;
    addr_i = misc_addr(sel, 1'b0);
    step_cycle();
    we_n_i = 1'b1;
    rise_edge = cycle_count;
    step_cycle();
    bus_idle();
  endtask

  // One access, low half then high half
  task automatic read_reg(input demod_pkg::misc_reg_e sel, input string name,
                          output int unsigned start_edge, output logic [31:0] value);
    step_cycle();
    cs_n_i = 1'b0;
    rd_n_i = 1'b0;
    addr_i = misc_addr(sel, 1'b0);
    start_edge = cycle_count;
    @(negedge ck933);
    check_flag({name, " enable"}, 1'b1, data_oe_o);
    repeat (2) step_cycle();
    @(negedge ck933);
    value[15:0] = data_o;
    step_cycle();
    addr_i = misc_addr(sel, 1'b1);
    step_cycle();
    @(negedge ck933);
    value[31:16] = data_o;
    step_cycle();
    bus_idle();
    @(negedge ck933);
    check_flag({name, " enable off"}, 1'b0, data_oe_o);
  endtask

  //************************************************************************
  // Tests
  //************************************************************************

  task automatic sample_path();
    logic [demod_pkg::ADC_W-1:0] adc;
    adc_queue.delete();
    for (int i = 0; i < SAMPLE_RUNS + 2; i++) begin
      step_cycle();
      adc = demod_pkg::ADC_W'($urandom());
      adc_d_i = adc;
      adc_queue.push_back(adc);
      @(negedge ck933);
      if (adc_queue.size() > 2) begin
        check_dac("sample path", expected_dac(adc_queue.pop_front()), dac_d_o);
      end
    end
  endtask

  task automatic version_read();
    int unsigned start_edge;
    logic [31:0] value;
    read_reg(demod_pkg::MISC_VERSION, "version", start_edge, value);
    check_bus("version low half", 16'h0000, value[15:0]);
    check_bus("version high half", demod_pkg::VER_NUMBER, value[31:16]);
    step_cycle();
    cs_n_i = 1'b0;                            // Select without read strobe
    addr_i = misc_addr(demod_pkg::MISC_VERSION, 1'b1);
    @(negedge ck933);
    check_flag("version no read enable", 1'b0, data_oe_o);
    step_cycle();
    bus_idle();
  endtask

  task automatic clock_counter();
    int unsigned we_edge;
    int unsigned start_edge;
    logic [31:0] value;
    logic [31:0] exp_hold;
    for (int n = 0; n < CLOCK_RUNS; n++) begin
      write_reg(demod_pkg::MISC_CLOCK, we_edge);
      repeat ($urandom_range(10, 200)) step_cycle();
      read_reg(demod_pkg::MISC_CLOCK, "clock counter", start_edge, value);
      // Clear two edges after we_n rise, capture two edges after select
      exp_hold = (start_edge + 2) - (we_edge + 2) - 1;
      check_bus("clock counter low half", exp_hold[15:0], value[15:0]);
      check_bus("clock counter high half", exp_hold[31:16], value[31:16]);
    end
  endtask

  task automatic soft_reset_seq();
    logic [demod_pkg::ADC_W-1:0] adc;
    logic                        exp_rst;
    step_cycle();
    adc = demod_pkg::ADC_W'($urandom_range(1, 16383));  // Never midscale
    adc_d_i = adc;
    cs_n_i = 1'b0;
    rd_n_i = 1'b0;
    addr_i = misc_addr(demod_pkg::MISC_RESET, 1'b0);
    for (int k = 0; k < SOFT_CYCLES - 1; k++) begin
      if (k > 0) step_cycle();
      if (k == 2) bus_idle();
      @(negedge ck933);
      if (k == 1) check_bus("reset register read", 16'h0000, data_o);
      exp_rst = (k >= 3) && (k <= 3 + demod_pkg::RESET_STRETCH);
      check_flag("soft reset dac_rst", exp_rst, dac_rst_o);
      if (k >= 4 && k <= 4 + demod_pkg::RESET_STRETCH) begin
        check_dac("soft reset midscale", demod_pkg::DAC_MIDSCALE, dac_d_o);
      end else if (k > 4 + demod_pkg::RESET_STRETCH) begin
        check_dac("soft reset resume", expected_dac(adc), dac_d_o);
      end
    end
  endtask

  task automatic unmapped_reads();
    logic [demod_pkg::ADDR_W-1:1] addr;
    for (int n = 0; n < UNMAPPED_RUNS; n++) begin
      do begin
        addr = (demod_pkg::ADDR_W-1)'($urandom());
      end while (addr[11:4] == demod_pkg::MISC_BASE[11:4]);
      step_cycle();
      cs_n_i = 1'b0;
      rd_n_i = 1'b0;
      addr_i = addr;
      @(negedge ck933);
      check_flag("unmapped enable", 1'b1, data_oe_o);
      step_cycle();
      @(negedge ck933);
      check_bus("unmapped read", 16'h0000, data_o);
      step_cycle();
      bus_idle();
    end
  endtask

  //************************************************************************
  // Main sequence
  //************************************************************************

  initial begin
    void'($urandom(32'hcc427e2f));
    ck933 = 1'b0;
    clockCounterEn = 1'b1;
    bus_idle();
    addr_i = '0;
    adc_d_i = '0;
    repeat (RESET_CYCLES) @(posedge ck933);
    #2 clockCounterEn = 1'b0;

    sample_path();
    finish_test("sample path");
    version_read();
    finish_test("version read");
    clock_counter();
    finish_test("clock counter");
    soft_reset_seq();
    finish_test("soft reset");
    unmapped_reads();
    finish_test("unmapped reads");

    $display("Summary: %0d tests, %0d checks, %0d errors", tests_run, check_total, err_count);
    if (err_count == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

//--- build.f
common/demod_pkg.sv
logic/host_decode.sv
misc/misc_regs.sv
misc/soft_reset.sv
logic/dac_path.sv
logic/demod_top.sv
sim/demod_checker.sv
sim/tb_demod_top.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Verilator build and run of the demodulator testbench
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f build.f \
    --top-module tb_demod_top -o sim_demod \
  && ./obj_dir/sim_demod | tee /dev/stderr | grep -qx "Test OK" \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }
